// File: run.sh
#!/bin/sh
# Build the spiLite testbench with Verilator, run it and check the log
set -e

verilator --binary --timing --assert --top-module tbSpiLite -f spiLite.f -o simSpiLite
./obj_dir/simSpiLite | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation passed"

// File: spiBusRegs.sv
// Host register block on the 8-bit strobe/ack bus.
// Decodes the register map, holds clock divider and command fields,
// and runs single direct-access bytes through its own requester port.
// Command start is passed on as a one cycle pulse.

`timescale 1ns/1ps

module spiBusRegs (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [7:0]            address_i,
  input  logic [7:0]            data_i,
  output logic [7:0]            data_o,
  input  logic                  strobe_i,
  input  logic                  we_i,
  output logic                  ack_o,
  spiByteIf.requester           directByte,
  output logic                  cmdStart_o,
  output spiLitePkg::cmdFrame_u cmdFrame_o,
  output logic [7:0]            clkDiv_o,
  input  logic                  cmdBusy_i,
  input  logic [7:0]            respByte_i,
  input  logic                  respTout_i
);
  import spiLitePkg::*;

  logic            ackReg;
  logic            strobeHeld;
  logic            directReq;
  logic            cmdStartReg;
  logic            busy;
  logic            ctrlWrite;
  logic [7:0]      clkDiv;
  logic [7:0]      txData;
  logic [7:0]      rxData;
  logic [7:0]      cmdIdx;
  logic [0:3][7:0] argBytes;
  logic [7:0]      crc;
  logic [7:0]      status;
  cmdFrame_u       frame;

  // Start pulse counts as busy until the sender raises its own flag
  assign busy      = directReq | cmdStartReg | cmdBusy_i;
  assign ctrlWrite = ackReg & we_i & (address_i == REG_CTRL);

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------
  // One ack per strobe, strobeHeld blocks a repeat while it stays high
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ackReg     <= 1'b0;
      strobeHeld <= 1'b0;
    end else begin
      ackReg     <= strobe_i & ~ackReg & ~strobeHeld;
      strobeHeld <= strobe_i & (ackReg | strobeHeld);
    end
  end

  assign ack_o = ackReg;

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      directReq   <= 1'b0;
      cmdStartReg <= 1'b0;
      clkDiv      <= 8'h00;
    end else begin
      cmdStartReg <= 1'b0;
      // Control writes while busy are dropped
      if (ctrlWrite && !busy) begin
        if (data_i[CTRL_CMD_BIT])
          cmdStartReg <= 1'b1;
        else if (data_i[CTRL_DIRECT_BIT])
          directReq <= 1'b1;
      end
      // Single byte only, release on done
      if (directByte.done)
        directReq <= 1'b0;
      if (ackReg && we_i && address_i == REG_CLKDIV)
        clkDiv <= data_i;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (ackReg && we_i) begin
      case (address_i)
        REG_TXDATA: txData      <= data_i;
        REG_CMDIDX: cmdIdx      <= data_i;
        REG_ARG0:   argBytes[0] <= data_i;
        REG_ARG1:   argBytes[1] <= data_i;
        REG_ARG2:   argBytes[2] <= data_i;
        REG_ARG3:   argBytes[3] <= data_i;
        REG_CRC:    crc         <= data_i;
        default: ;
      endcase
    end
    if (directByte.done)
      rxData <= directByte.rxByte;
  end

  assign directByte.req    = directReq;
  assign directByte.txByte = txData;

  // Frame assembled through the field view
  always_comb begin
    frame.fields.cmd = cmdIdx;
    frame.fields.arg = argBytes;
    frame.fields.crc = crc;
  end

  assign cmdFrame_o = frame;
  assign cmdStart_o = cmdStartReg;
  assign clkDiv_o   = clkDiv;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    status               = 8'h00;
    status[STS_BUSY_BIT] = busy;
    status[STS_TOUT_BIT] = respTout_i;
  end

  always_comb begin
    case (address_i)
      REG_STATUS: data_o = status;
      REG_TXDATA: data_o = txData;
      REG_RXDATA: data_o = rxData;
      REG_CLKDIV: data_o = clkDiv;
      REG_CMDIDX: data_o = cmdIdx;
      REG_ARG0:   data_o = argBytes[0];
      REG_ARG1:   data_o = argBytes[1];
      REG_ARG2:   data_o = argBytes[2];
      REG_ARG3:   data_o = argBytes[3];
      REG_CRC:    data_o = crc;
      REG_RESP:   data_o = respByte_i;
      default:    data_o = 8'h00;
    endcase
  end

  // Ack stays a single cycle pulse even under a long strobe
  ackSingle: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o);

endmodule

// File: spiByteArbiter.sv
// Shares the SPI byte engine between the direct and command requesters.
// Grant moves only between transactions, command path wins a tie.
// Chip select follows the grant.

`timescale 1ns/1ps

module spiByteArbiter (
  input  logic        clk_i,
  input  logic        rst_i,
  spiByteIf.engine    reqDirect,
  spiByteIf.engine    reqCmd,
  spiByteIf.requester toEngine,
  output logic        spiCS_n_o
);
  import spiLitePkg::*;

  logic grant;
  logic active;
  logic byteOpen;
  logic holderReq;
  logic cmdHolds;
  logic dirHolds;

  assign cmdHolds  = active & (grant == REQ_CMD);
  assign dirHolds  = active & (grant == REQ_DIRECT);
  assign holderReq = (grant == REQ_CMD) ? reqCmd.req : reqDirect.req;

  // Steering towards the engine
  assign toEngine.req    = active & holderReq;
  assign toEngine.txByte = (grant == REQ_CMD) ? reqCmd.txByte : reqDirect.txByte;

  // Results only to the holder
  assign reqCmd.done      = cmdHolds & toEngine.done;
  assign reqCmd.rxByte    = cmdHolds ? toEngine.rxByte : 8'h00;
  assign reqDirect.done   = dirHolds & toEngine.done;
  assign reqDirect.rxByte = dirHolds ? toEngine.rxByte : 8'h00;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      grant    <= REQ_DIRECT;
      active   <= 1'b0;
      byteOpen <= 1'b0;
    end else begin
      // Mirrors the engine busy state
      if (toEngine.done)
        byteOpen <= 1'b0;
      else if (toEngine.req)
        byteOpen <= 1'b1;
      if (!active) begin
        if (reqCmd.req) begin
          grant  <= REQ_CMD;
          active <= 1'b1;
        end else if (reqDirect.req) begin
          grant  <= REQ_DIRECT;
          active <= 1'b1;
        end
      end else if (!holderReq && !byteOpen) begin
        active <= 1'b0;
      end
    end
  end

  assign spiCS_n_o = ~active;

  // Done reaches only the holder that kept asking
  doneToDirect: assert property (@(posedge clk_i) disable iff (rst_i)
    reqDirect.done |-> (grant == REQ_DIRECT) && $past(reqDirect.req));
  doneToCmd: assert property (@(posedge clk_i) disable iff (rst_i)
    reqCmd.done |-> (grant == REQ_CMD) && $past(reqCmd.req));

endmodule

// File: spiByteIf.sv
// Byte transfer handshake between a requester and the SPI engine.
// Requester raises req with txByte, engine pulses done with rxByte.
// Keeping req high after done chains the next byte in the same
// transaction, dropping req ends it.

`timescale 1ns/1ps

interface spiByteIf;

  // Transfer request, held for the whole transaction
  logic       req;
  // Byte to shift out, valid while req is high
  logic [7:0] txByte;
  // Byte shifted in, valid while done is high
  logic [7:0] rxByte;
  // One cycle pulse per finished byte
  logic       done;

  modport requester (
    output req,
    output txByte,
    input  rxByte,
    input  done
  );

  modport engine (
    input  req,
    input  txByte,
    output rxByte,
    output done
  );

endinterface

// File: spiCmdSender.sv
// Sends a six byte card command and polls for the response.
// The frame is latched on cmdStart_i and walked out byte by byte,
// then fill bytes go out until a response byte or a timeout.
// req stays high for the whole command, cmdBusy_o falls at the end.

`timescale 1ns/1ps

module spiCmdSender (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cmdStart_i,
  input  spiLitePkg::cmdFrame_u cmdFrame_i,
  spiByteIf.requester           cmdByte,
  output logic                  cmdBusy_o,
  output logic [7:0]            respByte_o,
  output logic                  respTout_o
);
  import spiLitePkg::*;

  cmdFrame_u              frame;
  logic                   busy;
  logic                   polling;
  logic                   toutReg;
  logic [FRAME_IDX_W-1:0] byteIdx;
  logic [POLL_CNT_W-1:0]  pollCnt;
  logic [7:0]             respReg;
  logic                   startNow;
  logic                   lastFrameByte;
  logic                   lastPoll;
  logic                   gotResp;

  assign startNow      = cmdStart_i & ~busy;
  assign lastFrameByte = byteIdx == FRAME_IDX_W'(CMD_FRAME_BYTES - 1);
  assign lastPoll      = pollCnt == POLL_CNT_W'(RESP_TRIES - 1);
  // Card response has its top bit clear
  assign gotResp       = cmdByte.done & polling & ~cmdByte.rxByte[7];

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy    <= 1'b0;
      polling <= 1'b0;
      toutReg <= 1'b0;
      byteIdx <= '0;
      pollCnt <= '0;
    end else if (startNow) begin
      busy    <= 1'b1;
      polling <= 1'b0;
      toutReg <= 1'b0;
      byteIdx <= '0;
      pollCnt <= '0;
    end else if (busy && cmdByte.done) begin
      if (!polling) begin
        // Frame phase
        if (lastFrameByte)
          polling <= 1'b1;
        else
          byteIdx <= byteIdx + 1'b1;
      end else if (gotResp) begin
        busy <= 1'b0;
      end else if (lastPoll) begin
        // Out of tries
        toutReg <= 1'b1;
        busy    <= 1'b0;
      end else begin
        pollCnt <= pollCnt + 1'b1;
      end
    end
  end

  // Frame and response payload
  always_ff @(posedge clk_i) begin
    if (startNow) begin
      frame          <= cmdFrame_i;
      frame.bytes[0] <= cmdFrame_i.bytes[0] | CMD_START_BITS;
    end
    if (gotResp)
      respReg <= cmdByte.rxByte;
  end

  // Next byte shows up the cycle after done, from the updated counter
  assign cmdByte.req    = busy;
  assign cmdByte.txByte = polling ? POLL_FILL : frame.bytes[byteIdx];

  assign cmdBusy_o  = busy;
  assign respByte_o = respReg;
  assign respTout_o = toutReg;

  // Register block starts a command only while the sender is idle
  startWhenIdle: assert property (@(posedge clk_i) disable iff (rst_i)
    cmdStart_i |-> !busy);

endmodule

// File: spiLite.f
spiLitePkg.sv
spiByteIf.sv
spiBusRegs.sv
spiCmdSender.sv
spiByteArbiter.sv
spiWireShifter.sv
spiLite.sv
tbSpiLite.sv

// File: spiLite.sv
// Top level of the spiLite SPI master.
// Host register bus and SPI wires as plain ports, the rest is
// instances joined by three byte-transfer interfaces.

`timescale 1ns/1ps

module spiLite (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [7:0] address_i,
  input  logic [7:0] data_i,
  output logic [7:0] data_o,
  input  logic       strobe_i,
  input  logic       we_i,
  output logic       ack_o,
  output logic       spiClkOut,
  output logic       spiDataOut,
  input  logic       spiDataIn,
  output logic       spiCS_n
);
  import spiLitePkg::*;

  logic       cmdStart;
  cmdFrame_u  cmdFrame;
  logic [7:0] clkDiv;
  logic       cmdBusy;
  logic [7:0] respByte;
  logic       respTout;

  // Requester links into the arbiter, and arbiter to engine
  spiByteIf directByte ();
  spiByteIf cmdByte ();
  spiByteIf engineByte ();

  // ----------------------------------------
  // Register block
  // ----------------------------------------
  spiBusRegs u_spiBusRegs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .address_i  (address_i),
    .data_i     (data_i),
    .data_o     (data_o),
    .strobe_i   (strobe_i),
    .we_i       (we_i),
    .ack_o      (ack_o),
    .directByte (directByte.requester),
    .cmdStart_o (cmdStart),
    .cmdFrame_o (cmdFrame),
    .clkDiv_o   (clkDiv),
    .cmdBusy_i  (cmdBusy),
    .respByte_i (respByte),
    .respTout_i (respTout)
  );

  spiCmdSender u_spiCmdSender (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cmdStart_i (cmdStart),
    .cmdFrame_i (cmdFrame),
    .cmdByte    (cmdByte.requester),
    .cmdBusy_o  (cmdBusy),
    .respByte_o (respByte),
    .respTout_o (respTout)
  );

  // ----------------------------------------
  // Engine sharing and wires
  // ----------------------------------------
  spiByteArbiter u_spiByteArbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reqDirect (directByte.engine),
    .reqCmd    (cmdByte.engine),
    .toEngine  (engineByte.requester),
    .spiCS_n_o (spiCS_n)
  );

  spiWireShifter u_spiWireShifter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .clkDiv_i     (clkDiv),
    .byteXfer     (engineByte.engine),
    .spiClkOut_o  (spiClkOut),
    .spiDataOut_o (spiDataOut),
    .spiDataIn_i  (spiDataIn)
  );

endmodule

// File: spiLitePkg.sv
// Shared definitions for the spiLite SPI master.
// Holds the host register map, control and status bit positions,
// command frame sizes and the command frame union.
// Modules import it with a wildcard inside their body.

package spiLitePkg;

  // ----------------------------------------
  // Host register map
  // ----------------------------------------
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_STATUS = 8'h01;
  localparam logic [7:0] REG_TXDATA = 8'h02;
  localparam logic [7:0] REG_RXDATA = 8'h03;
  localparam logic [7:0] REG_CLKDIV = 8'h04;
  localparam logic [7:0] REG_CMDIDX = 8'h05;
  // Argument bytes, ARG0 is the most significant and goes out first
  localparam logic [7:0] REG_ARG0   = 8'h06;
  localparam logic [7:0] REG_ARG1   = 8'h07;
  localparam logic [7:0] REG_ARG2   = 8'h08;
  localparam logic [7:0] REG_ARG3   = 8'h09;
  localparam logic [7:0] REG_CRC    = 8'h0A;
  localparam logic [7:0] REG_RESP   = 8'h0B;

  // Control write bits
  localparam int CTRL_DIRECT_BIT = 0;
  localparam int CTRL_CMD_BIT    = 1;

  // Status read bits
  localparam int STS_BUSY_BIT = 0;
  localparam int STS_TOUT_BIT = 1;

  // ----------------------------------------
  // Command frame
  // ----------------------------------------
  localparam int CMD_FRAME_BYTES = 6;
  localparam int RESP_TRIES      = 8;
  localparam int FRAME_IDX_W     = $clog2(CMD_FRAME_BYTES);
  localparam int POLL_CNT_W      = $clog2(RESP_TRIES);
  localparam logic [7:0] CMD_START_BITS = 8'h40;
  localparam logic [7:0] POLL_FILL      = 8'hFF;

  // Arbiter requester index
  localparam logic REQ_DIRECT = 1'b0;
  localparam logic REQ_CMD    = 1'b1;

  // Same 48 bits seen as fields or as bytes, MS byte first
  typedef union packed {
    struct packed {
      logic [7:0]  cmd;
      logic [31:0] arg;
      logic [7:0]  crc;
    } fields;
    logic [0:CMD_FRAME_BYTES-1][7:0] bytes;
  } cmdFrame_u;

endpackage

// File: spiWireShifter.sv
// Byte shift engine on the SPI wires, mode 0, MSB first.
// The SPI clock half period is clkDiv_i+1 clock cycles.
// MOSI changes on falling edges, MISO is sampled on rising edges,
// and done pulses once all 16 edges of a byte have passed.

`timescale 1ns/1ps

module spiWireShifter (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [7:0] clkDiv_i,
  spiByteIf.engine   byteXfer,
  output logic       spiClkOut_o,
  output logic       spiDataOut_o,
  input  logic       spiDataIn_i
);

  logic       busy;
  logic       doneReg;
  logic       sck;
  logic       mosi;
  logic [7:0] divCnt;
  logic [3:0] edgeCnt;
  logic [7:0] txShift;
  logic [7:0] rxShift;
  logic       accept;
  logic       tick;

  // No accept in the done cycle, requester updates txByte after it
  assign accept = ~busy & ~doneReg & byteXfer.req;
  assign tick   = busy & (divCnt >= clkDiv_i);

  // ----------------------------------------
  // Divider and edge counter
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy    <= 1'b0;
      doneReg <= 1'b0;
      sck     <= 1'b0;
      mosi    <= 1'b1;
      divCnt  <= 8'h00;
      edgeCnt <= 4'h0;
    end else begin
      doneReg <= 1'b0;
      if (accept) begin
        busy    <= 1'b1;
        divCnt  <= 8'h00;
        edgeCnt <= 4'h0;
        // First bit out before the first rising edge
        mosi    <= byteXfer.txByte[7];
      end else if (tick) begin
        divCnt  <= 8'h00;
        sck     <= ~sck;
        edgeCnt <= edgeCnt + 4'h1;
        if (sck) begin
          // Falling edge
          if (edgeCnt == 4'hF) begin
            busy    <= 1'b0;
            doneReg <= 1'b1;
            mosi    <= 1'b1;
          end else begin
            mosi <= txShift[6];
          end
        end
      end else if (busy) begin
        divCnt <= divCnt + 8'h01;
      end
    end
  end

  // Shift registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      txShift <= byteXfer.txByte;
    end else if (tick) begin
      if (!sck)
        rxShift <= {rxShift[6:0], spiDataIn_i};
      else
        txShift <= {txShift[6:0], 1'b1};
    end
  end

  assign byteXfer.done   = doneReg;
  assign byteXfer.rxByte = rxShift;
  assign spiClkOut_o     = sck;
  assign spiDataOut_o    = mosi;

  // Done only closes a byte that was in flight
  doneInXfer: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(byteXfer.done) |-> $past(busy));

endmodule

// File: tbSpiLite.sv
// Testbench for the spiLite SPI master.
// Drives the host register bus, models a mode 0 card on the SPI wires
// and checks registers, wire timing and command traffic with assertions.
// Built and run by run.sh.

`timescale 1ns/1ps

module tbSpiLite;
  import spiLitePkg::*;

  // Whole run is a few commands of up to 14 bytes at 64 cycles, plenty of margin
  localparam int CYCLE_LIMIT = 20000;

  logic       clk;
  logic       rst;
  logic [7:0] address;
  logic [7:0] dataIn;
  logic [7:0] dataOut;
  logic       strobe;
  logic       we;
  logic       ack;
  logic       spiClkOut;
  logic       spiDataOut;
  logic       spiDataIn;
  logic       spiCS_n;

  logic [31:0] lfsrState;
  int          mismatchCnt;
  int          phaseErrCnt;
  int          assertErrCnt;
  int          ackCnt;
  int          cycleCnt;
  int          expHalf;
  int          highCnt;
  int          highPhases;

  // Card model state
  logic [7:0] cardTx[$];
  logic [7:0] cardRx[$];
  logic [7:0] misoByte;
  logic [2:0] misoBit;
  logic [7:0] mosiShift;
  int         mosiBits;
  logic       sckPrev;
  logic       csPrev;

  spiLite dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .address_i  (address),
    .data_i     (dataIn),
    .data_o     (dataOut),
    .strobe_i   (strobe),
    .we_i       (we),
    .ack_o      (ack),
    .spiClkOut  (spiClkOut),
    .spiDataOut (spiDataOut),
    .spiDataIn  (spiDataIn),
    .spiCS_n    (spiCS_n)
  );

  always #20 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Galois LFSR, one step per random bit
  function automatic logic lfsrStep();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ 32'hD000_0001;
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsrStep()};
    return v;
  endfunction

  function automatic logic [7:0] randByte();
    return 8'(randBits(8));
  endfunction

  // Idle card answers all ones
  function automatic logic [7:0] nextCardByte();
    logic [7:0] b;
    b = 8'hFF;
    if (cardTx.size() != 0)
      b = cardTx.pop_front();
    return b;
  endfunction

  task automatic checkByte(input string sigName, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      mismatchCnt = mismatchCnt + 1;
      $display("MISMATCH at %0t: %s got %02h expected %02h", $time, sigName, got, exp);
    end
  endtask

  task automatic checkNum(input string sigName, input int got, input int exp);
    assert (got == exp) else begin
      mismatchCnt = mismatchCnt + 1;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, sigName, got, exp);
    end
  endtask

  task automatic printCounts();
    $display("Errors: %0d value mismatches, %0d clock phase errors, %0d protocol errors",
             mismatchCnt, phaseErrCnt, assertErrCnt);
  endtask

  // ----------------------------------------
  // Host bus
  // ----------------------------------------
  task automatic busAccess(input logic [7:0] addr, input logic [7:0] val, input logic write,
                           output logic [7:0] rd);
    int acksBefore;
    acksBefore = ackCnt;
    address = addr;
    dataIn  = val;
    we      = write;
    strobe  = 1'b1;
    do @(negedge clk); while (ack !== 1'b1);
    rd = dataOut;
    // Held over the ack cycle, write data lands there
    @(negedge clk);
    strobe = 1'b0;
    we     = 1'b0;
    @(negedge clk);
    checkNum("ack_o count", ackCnt - acksBefore, 1);
  endtask

  task automatic busWrite(input logic [7:0] addr, input logic [7:0] val);
    logic [7:0] unused;
    busAccess(addr, val, 1'b1, unused);
  endtask

  task automatic busRead(input logic [7:0] addr, output logic [7:0] val);
    busAccess(addr, 8'h00, 1'b0, val);
  endtask

  task automatic waitIdle();
    logic [7:0] sts;
    do busRead(REG_STATUS, sts); while (sts[STS_BUSY_BIT]);
  endtask

  task automatic roundTrip(input string regName, input logic [7:0] addr);
    logic [7:0] val;
    logic [7:0] rd;
    val = randByte();
    busWrite(addr, val);
    busRead(addr, rd);
    checkByte(regName, rd, val);
  endtask

  // ----------------------------------------
  // Transfers
  // ----------------------------------------
  task automatic directXfer(input logic [7:0] div);
    logic [7:0] txVal;
    logic [7:0] cardVal;
    logic [7:0] rd;
    int         phasesBefore;
    busWrite(REG_CLKDIV, div);
    expHalf = int'(div) + 1;
    txVal   = randByte();
    cardVal = randByte();
    cardTx.delete();
    cardRx.delete();
    cardTx.push_back(cardVal);
    phasesBefore = highPhases;
    busWrite(REG_TXDATA, txVal);
    busWrite(REG_CTRL, 8'(1 << CTRL_DIRECT_BIT));
    waitIdle();
    // Chip select follows the dropped request within two cycles
    repeat (2) @(negedge clk);
    checkByte("spiCS_n", 8'(spiCS_n), 8'h01);
    checkNum("card byte count", cardRx.size(), 1);
    checkByte("card MOSI byte", cardRx[0], txVal);
    checkNum("spiClkOut high phases", highPhases - phasesBefore, 8);
    busRead(REG_RXDATA, rd);
    checkByte("REG_RXDATA", rd, cardVal);
  endtask

  // Card answers after nFill fill bytes, or never
  task automatic runCmd(input int nFill, input logic answers, input logic pokeCtrl);
    logic [7:0]  idx;
    logic [31:0] arg;
    logic [7:0]  crc;
    logic [7:0]  resp;
    logic [7:0]  rd;
    int          nPolls;
    idx    = 8'(randBits(6));
    arg    = randBits(32);
    crc    = randByte();
    resp   = randByte() & 8'h7F;
    nPolls = answers ? nFill + 1 : RESP_TRIES;
    cardTx.delete();
    if (answers) begin
      repeat (CMD_FRAME_BYTES + nFill) cardTx.push_back(8'hFF);
      cardTx.push_back(resp);
    end
    busWrite(REG_CMDIDX, idx);
    busWrite(REG_ARG0, arg[31:24]);
    busWrite(REG_ARG1, arg[23:16]);
    busWrite(REG_ARG2, arg[15:8]);
    busWrite(REG_ARG3, arg[7:0]);
    busWrite(REG_CRC, crc);
    cardRx.delete();
    busWrite(REG_CTRL, 8'(1 << CTRL_CMD_BIT));
    if (pokeCtrl) begin
      busRead(REG_STATUS, rd);
      checkByte("REG_STATUS busy bit", 8'(rd[STS_BUSY_BIT]), 8'h01);
      busWrite(REG_CTRL, 8'(1 << CTRL_DIRECT_BIT));
    end
    waitIdle();
    // Frame bytes in order, then fill bytes only
    checkNum("card byte count", cardRx.size(), CMD_FRAME_BYTES + nPolls);
    checkByte("card command byte", cardRx[0], idx | CMD_START_BITS);
    for (int i = 0; i < 4; i++)
      checkByte("card argument byte", cardRx[i + 1], 8'(arg >> (24 - 8 * i)));
    checkByte("card CRC byte", cardRx[5], crc);
    for (int i = CMD_FRAME_BYTES; i < cardRx.size(); i++)
      checkByte("card poll byte", cardRx[i], POLL_FILL);
    busRead(REG_STATUS, rd);
    checkByte("REG_STATUS", rd, answers ? 8'h00 : 8'(1 << STS_TOUT_BIT));
    if (answers) begin
      busRead(REG_RESP, rd);
      checkByte("REG_RESP", rd, resp);
    end
  endtask

  // ----------------------------------------
  // Card model, mode 0
  // ----------------------------------------
  always @(negedge clk) begin
    if (!spiCS_n && csPrev) begin
      // First bit ready before the first rising edge
      misoByte  = nextCardByte();
      misoBit   = 3'd7;
      mosiBits  = 0;
      spiDataIn = misoByte[7];
    end else if (!spiCS_n && spiClkOut && !sckPrev) begin
      mosiShift = {mosiShift[6:0], spiDataOut};
      mosiBits  = mosiBits + 1;
      if (mosiBits == 8) begin
        cardRx.push_back(mosiShift);
        mosiBits = 0;
      end
    end else if (!spiCS_n && !spiClkOut && sckPrev) begin
      if (misoBit == 3'd0) begin
        misoByte = nextCardByte();
        misoBit  = 3'd7;
      end else begin
        misoBit = misoBit - 3'd1;
      end
      spiDataIn = misoByte[misoBit];
    end
    sckPrev = spiClkOut;
    csPrev  = spiCS_n;
  end

  // SPI clock high phase length
  always @(negedge clk) begin
    if (spiClkOut) begin
      highCnt = highCnt + 1;
    end else if (highCnt != 0) begin
      highPhases = highPhases + 1;
      assert (highCnt == expHalf) else begin
        phaseErrCnt = phaseErrCnt + 1;
        $display("MISMATCH at %0t: spiClkOut half period got %0d expected %0d",
                 $time, highCnt, expHalf);
      end
      highCnt = 0;
    end
  end

  always @(negedge clk) begin
    if (ack)
      ackCnt = ackCnt + 1;
  end

  always @(posedge clk) begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      printCounts();
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Protocol assertions
  // ----------------------------------------
  ackSinglePulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      assertErrCnt = assertErrCnt + 1;
      $display("At %0t ack_o stayed high for two cycles", $time);
    end
  ackOnStrobe: assert property (@(posedge clk) disable iff (rst) ack |-> strobe)
    else begin
      assertErrCnt = assertErrCnt + 1;
      $display("At %0t ack_o came without a strobe", $time);
    end
  sckInsideCs: assert property (@(posedge clk) disable iff (rst) spiClkOut |-> !spiCS_n)
    else begin
      assertErrCnt = assertErrCnt + 1;
      $display("At %0t spiClkOut toggled while chip select was high", $time);
    end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    address      = 8'h00;
    dataIn       = 8'h00;
    strobe       = 1'b0;
    we           = 1'b0;
    spiDataIn    = 1'b1;
    sckPrev      = 1'b0;
    csPrev       = 1'b1;
    lfsrState    = 32'hd8f5_30c3;
    mismatchCnt  = 0;
    phaseErrCnt  = 0;
    assertErrCnt = 0;
    ackCnt       = 0;
    cycleCnt     = 0;
    expHalf      = 1;
    highCnt      = 0;
    highPhases   = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Idle wires and register round trips
    checkByte("spiCS_n", 8'(spiCS_n), 8'h01);
    checkByte("spiClkOut", 8'(spiClkOut), 8'h00);
    checkByte("spiDataOut", 8'(spiDataOut), 8'h01);
    checkByte("ack_o", 8'(ack), 8'h00);
    roundTrip("REG_CLKDIV", REG_CLKDIV);
    roundTrip("REG_ARG0", REG_ARG0);
    roundTrip("REG_ARG1", REG_ARG1);
    roundTrip("REG_ARG2", REG_ARG2);
    roundTrip("REG_ARG3", REG_ARG3);

    // Direct bytes at two divider settings
    directXfer(8'd1);
    directXfer(8'd3);

    // Fill count 0..7 stays below RESP_TRIES
    runCmd(int'(randBits(3)), 1'b1, 1'b0);
    runCmd(0, 1'b0, 1'b0);
    // Control write during a command, then a direct byte
    runCmd(2, 1'b1, 1'b1);
    directXfer(8'd3);

    printCounts();
    if (mismatchCnt + phaseErrCnt + assertErrCnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
